/* design/div_decode.sv */
`timescale 1ns/1ps

module div_decode
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  div_op_t  op,
    input  word_t    rs1,
    input  word_t    rs2,
    input  logic     done,
    output logic     busy,
    output logic     start,
    output div_req_t req,
    output div_ctx_t ctx
);

    logic     busy_r;       // Set at acceptance, cleared once done is seen.
    logic     accept;       // An issue is taken on this edge.
    logic     is_signed;    // DIV and REM treat the operands as signed.
    logic     rs1_neg;      // Dividend is negative and must be negated.
    logic     rs2_neg;      // Divisor is negative and must be negated.
    word_t    rs1_mag;
    word_t    rs2_mag;
    div_req_t req_next;
    div_ctx_t ctx_next;

    // The unit frees up in the cycle where the core reports done.
    // That lets a new issue be taken while the last result is still on its way out.
    assign busy = busy_r & ~done;

    assign accept = issue & ~busy; // An issue during busy is simply dropped.

    // Bit 0 of the opcode marks the unsigned variants.
    assign is_signed = ~op[0];
    assign rs1_neg   = is_signed & rs1[XLEN-1];
    assign rs2_neg   = is_signed & rs2[XLEN-1];

    // Two's-complement magnitudes. The most negative value maps onto itself,
    // which as an unsigned number is exactly its magnitude.
    assign rs1_mag = rs1_neg ? word_t'(-rs1) : rs1;
    assign rs2_mag = rs2_neg ? word_t'(-rs2) : rs2;

    always_comb begin
        req_next.dividend_mag = rs1_mag;
        req_next.divisor_mag  = rs2_mag;
        ctx_next.want_rem     = op[1];              // Bit 1 selects REM and REMU.
        ctx_next.neg_quot     = rs1_neg ^ rs2_neg;  // Quotient sign is the xor of signs.
        ctx_next.neg_rem      = rs1_neg;            // Remainder follows the dividend sign.
        ctx_next.div_zero     = (rs2 == '0);        // Only zero test in the unit.
    end

    // Control state. start is a single-cycle pulse after each accepted issue.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_r <= 1'b0;
            start  <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy_r <= 1'b1; // Held until the core finishes.
            end else if (done) begin
                busy_r <= 1'b0; // Nothing new arrived with done.
            end
        end
    end

    // Operands and flags stay put until the next accepted issue.
    always_ff @(posedge clk) begin
        if (accept) begin
            req <= req_next;
            ctx <= ctx_next;
        end
    end

endmodule

/* design/div_pkg.sv */
package div_pkg;

    // Data width of the integer datapath.
    localparam int XLEN = 32;

    // Operands, magnitudes, quotient, remainder and result all share this type.
    typedef logic [XLEN-1:0] word_t;

    // Operation code taken from the low two bits of funct3.
    typedef logic [1:0] div_op_t;

    localparam div_op_t OP_DIV  = 2'd0; // Signed quotient.
    localparam div_op_t OP_DIVU = 2'd1; // Unsigned quotient.
    localparam div_op_t OP_REM  = 2'd2; // Signed remainder.
    localparam div_op_t OP_REMU = 2'd3; // Unsigned remainder.

    // Latency from the accepting edge to the edge that raises result_valid.
    localparam int DIV_LATENCY = XLEN + 3;

    // States of the iterative divider core.
    typedef enum logic {
        CORE_IDLE, // Waiting for a start pulse.
        CORE_RUN   // Producing one quotient bit per cycle.
    } core_state_e;

    // Unsigned magnitudes handed from decode to the divider core.
    typedef struct packed {
        word_t dividend_mag; // Absolute value of rs1 for signed ops.
        word_t divisor_mag;  // Absolute value of rs2 for signed ops.
    } div_req_t;

    // Per-operation flags handed from decode to the result stage.
    typedef struct packed {
        logic want_rem; // The operation returns the remainder.
        logic neg_quot; // Operand signs differ on a signed operation.
        logic neg_rem;  // The dividend is negative on a signed operation.
        logic div_zero; // The divisor is zero.
    } div_ctx_t;

endpackage

/* design/div_radix2_core.sv */
`timescale 1ns/1ps

module div_radix2_core
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  div_req_t req,
    output logic     done,
    output word_t    quotient,
    output word_t    remainder
);

    // One extra bit so the counter can reach XLEN itself.
    localparam int CNT_W = $clog2(XLEN) + 1;

    core_state_e      state;
    logic [CNT_W-1:0] count;     // Number of quotient bits produced so far.
    word_t            divisor_r; // Divisor captured at start.
    word_t            rem_r;     // Partial remainder.
    word_t            quot_r;    // Dividend bits shift out as quotient bits shift in.
    logic [XLEN:0]    shifted;   // Partial remainder with the next dividend bit appended.
    logic [XLEN+1:0]  diff;      // Trial subtraction with room for the borrow.
    logic             borrow;    // Trial subtraction went negative.
    logic             load;
    logic             step;
    logic             last;

    // Bring down the next dividend bit from the top of the quotient register.
    assign shifted = {rem_r, quot_r[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_r};
    assign borrow  = diff[XLEN+1];

    assign last = (count == CNT_W'(XLEN)); // All quotient bits are in.
    assign load = start & (state == CORE_IDLE);
    assign step = (state == CORE_RUN) & ~last;

    // State machine and iteration count.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CORE_IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0; // done is only ever a single pulse.
            case (state)
                CORE_IDLE: begin
                    if (start) begin
                        state <= CORE_RUN;
                        count <= '0;
                    end
                end
                CORE_RUN: begin
                    if (last) begin
                        state <= CORE_IDLE; // One edge after the final bit.
                        done  <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= CORE_IDLE;
                end
            endcase
        end
    end

    // Restoring datapath. One quotient bit per edge, MSB first.
    always_ff @(posedge clk) begin
        if (load) begin
            divisor_r <= req.divisor_mag;
            rem_r     <= '0;
            quot_r    <= req.dividend_mag;
        end else if (step) begin
            // Keep the difference only when the divisor fit.
            rem_r  <= borrow ? shifted[XLEN-1:0] : diff[XLEN-1:0];
            quot_r <= {quot_r[XLEN-2:0], ~borrow};
        end
    end

    // A zero divisor never borrows. The quotient fills with ones and the
    // remainder ends up holding the whole dividend magnitude.
    assign quotient  = quot_r;
    assign remainder = rem_r;

endmodule

/* design/div_result.sv */
`timescale 1ns/1ps

module div_result
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     done,
    input  div_ctx_t ctx,
    input  word_t    quotient,
    input  word_t    remainder,
    output logic     result_valid,
    output word_t    result
);

    logic  quot_flip; // The quotient must change sign.
    word_t quot_fix;  // Quotient with its final sign.
    word_t rem_fix;   // Remainder with its final sign.
    word_t sel;       // Value that goes out for this operation.

    // Division by zero keeps the all-ones quotient regardless of operand signs.
    assign quot_flip = ctx.neg_quot & ~ctx.div_zero;

    // Overflow needs no special handling here.
    // A magnitude of 2^31 with no flip already reads back as the most negative value.
    assign quot_fix = quot_flip ? word_t'(-quotient) : quotient;

    // The remainder takes the sign of the dividend. For a zero divisor this
    // gives back the original dividend.
    assign rem_fix = ctx.neg_rem ? word_t'(-remainder) : remainder;

    assign sel = ctx.want_rem ? rem_fix : quot_fix;

    // result_valid mirrors done one edge later.
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= done;
        end
    end

    // The result holds until the next operation completes.
    always_ff @(posedge clk) begin
        if (done) begin
            result <= sel;
        end
    end

endmodule

/* design/div_unit.sv */
`timescale 1ns/1ps

module div_unit
    import div_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    issue,  // Strobe. Ignored while busy.
    input  div_op_t op,
    input  word_t   rs1,    // Dividend.
    input  word_t   rs2,    // Divisor.
    output logic    busy,
    output logic    result_valid,
    output word_t   result
);

    logic     start;     // Decode tells the core to load.
    logic     done;      // Core finished its iterations.
    div_req_t req;       // Operand magnitudes.
    div_ctx_t ctx;       // Sign and selection flags for the result stage.
    word_t    quotient;
    word_t    remainder;

    // Accepts the operation and forms magnitudes and flags.
    div_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .op    (op),
        .rs1   (rs1),
        .rs2   (rs2),
        .done  (done),
        .busy  (busy),
        .start (start),
        .req   (req),
        .ctx   (ctx)
    );

    // Unsigned iterative divider.
    div_radix2_core u_core (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .req       (req),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // Restores signs and picks the quotient or the remainder.
    div_result u_result (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .ctx          (ctx),
        .quotient     (quotient),
        .remainder    (remainder),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* div_unit.f */
design/div_pkg.sv
design/div_decode.sv
design/div_radix2_core.sv
design/div_result.sv
design/div_unit.sv
sim/div_unit_chk.sv
sim/div_unit_tb.sv

/* sim/div_unit_chk.sv */
`timescale 1ns/1ps

module div_unit_chk
    import div_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        issue,
    input logic        busy,
    input logic        start,
    input logic        result_valid,
    input core_state_e core_state
);

    logic accepted;

    assign accepted = issue & ~busy; // Same rule the decode stage uses to take an issue.

    // A new start must never land on top of a running iteration.
    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> (core_state != CORE_RUN)
    ) else $error("start seen while the divider core was in CORE_RUN");

    // result_valid is a single-cycle pulse.
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (rst) result_valid |=> !result_valid
    ) else $error("result_valid held high for two cycles in a row");

    // result_valid rises on the edge DIV_LATENCY after acceptance.
    // It is therefore first sampled high one edge after that.
    a_latency: assert property (
        @(posedge clk) disable iff (rst)
            accepted |=> ##DIV_LATENCY result_valid
    ) else $error("result_valid did not follow an accepted issue after exactly 35 edges");

    a_idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !busy
    ) else $error("busy was high in the cycle after reset");

endmodule

/* sim/div_unit_tb.sv */
`timescale 1ns/1ps

module div_unit_tb
    import div_pkg::*;
();

    localparam int CLK_PERIOD = 20;                  // Clock period in ns.
    localparam int LATENCY    = XLEN + 3;            // Edges from acceptance to result_valid.
    localparam int N_UNSIGNED = 200;
    localparam int N_SIGNED   = 200;                 // 25 per operation and sign pair.
    localparam int N_CORNER   = 14;                  // 12 zero divisors and 2 overflows.
    localparam int N_B2B      = 20;
    localparam int N_BUSY     = 10;
    localparam int NUM_OPS    = N_UNSIGNED + N_SIGNED + N_CORNER + N_B2B + N_BUSY;
    localparam int TIMEOUT_NS = NUM_OPS * (XLEN + 5) * CLK_PERIOD + 2000;

    localparam word_t MIN_INT  = {1'b1, {(XLEN-1){1'b0}}}; // Most negative signed value.
    localparam word_t ALL_ONES = '1;                        // Minus one when read as signed.

    logic    clk;
    logic    rst;
    logic    issue;
    div_op_t op;
    word_t   rs1;
    word_t   rs2;
    logic    busy;
    logic    result_valid;
    word_t   result;

    int          cycle = 0;      // Rising edges seen so far.
    int          pass_count = 0;
    int          fail_count = 0;
    int          cur_test = 0;   // Test that owns an unexpected result.
    int          test_checks [6];
    int          test_errors [6];
    string       test_name [6];
    word_t       exp_q [$];      // Expected results in issue order.
    int          id_q [$];       // Test that issued each pending operation.
    int          cyc_q [$];      // Edge count at which each operation was accepted.
    int unsigned seed_val;

    div_unit u_dut (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .op           (op),
        .rs1          (rs1),
        .rs2          (rs2),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    // The protocol checker sees the internal start pulse and the core state.
    bind div_unit div_unit_chk u_chk (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .busy         (busy),
        .start        (start),
        .result_valid (result_valid),
        .core_state   (u_core.state)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk; // 50 MHz.
    end

    always @(posedge clk) cycle <= cycle + 1; // Edge counter for latency checks.

    // RISC-V M-extension results, worked out per operation.
    function automatic word_t div_model(input div_op_t o, input word_t a, input word_t b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        word_t                  res;
        sa = a;
        sb = b;
        case (o)
            OP_DIVU: res = (b == '0) ? ALL_ONES : a / b;   // Zero divisor gives all ones.
            OP_REMU: res = (b == '0) ? a : a % b;          // Zero divisor returns the dividend.
            OP_DIV: begin
                if (b == '0) res = ALL_ONES;
                else if (a == MIN_INT && b == ALL_ONES) res = MIN_INT; // Signed overflow.
                else res = sa / sb;                        // Truncates toward zero.
            end
            default: begin
                if (b == '0) res = a;
                else if (a == MIN_INT && b == ALL_ONES) res = '0;
                else res = sa % sb;                        // Takes the sign of the dividend.
            end
        endcase
        return res;
    endfunction

    task automatic record_check(input int id, input logic ok);
        test_checks[id]++;
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
            test_errors[id]++;
        end
    endtask

    // Waits for a free cycle, issues one operation and queues its expected result.
    task automatic send_op(input int id, input div_op_t o, input word_t a, input word_t b,
                           output int accept_cyc);
        @(posedge clk);
        #1;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        issue = 1'b1;
        op    = o;
        rs1   = a;
        rs2   = b;
        @(posedge clk);                  // This edge takes the issue since busy was low.
        #1;
        issue      = 1'b0;
        accept_cyc = cycle;
        exp_q.push_back(div_model(o, a, b));
        id_q.push_back(id);
        cyc_q.push_back(cycle);
    endtask

    task automatic finish_test(input int id);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Test %s finished: %0d checks, %0d errors",
                 test_name[id], test_checks[id], test_errors[id]);
    endtask

    task automatic run_unsigned();
        word_t a;
        word_t b;
        int    acc;
        for (int i = 0; i < N_UNSIGNED; i++) begin
            a = $urandom();
            case (i % 4)
                0: b = ($urandom() % 32'hffff) + 1; // Small divisor, mostly below the dividend.
                1: b = a;                            // Equal operands.
                2: begin
                    a = a >> 8;
                    b = $urandom() | MIN_INT;        // Divisor above the dividend.
                end
                default: b = $urandom();
            endcase
            send_op(1, ((i / 4) % 2 == 0) ? OP_DIVU : OP_REMU, a, b, acc);
        end
    endtask

    task automatic run_signed();
        word_t a;
        word_t b;
        int    acc;
        for (int s = 0; s < 4; s++) begin
            for (int j = 0; j < N_SIGNED / 4; j++) begin
                a = $urandom() & 32'h7fff_ffff;
                b = (($urandom() >> ($urandom() % 31)) & 32'h7fff_ffff) | 32'd1;
                if (s / 2 == 1) a = -a;          // Upper bit of s picks a negative dividend.
                if (s % 2 == 1) b = -b;          // Lower bit picks a negative divisor.
                send_op(2, (j % 2 == 0) ? OP_DIV : OP_REM, a, b, acc);
            end
        end
    endtask

    task automatic run_corners();
        word_t dvd [3];
        int    acc;
        dvd[0] = $urandom();
        dvd[1] = MIN_INT;
        dvd[2] = 32'hffff_fff9;
        for (int k = 0; k < 3; k++) begin
            for (int o = 0; o < 4; o++) begin
                send_op(3, div_op_t'(o), dvd[k], '0, acc); // Zero divisor on every opcode.
            end
        end
        send_op(3, OP_DIV, MIN_INT, ALL_ONES, acc);
        send_op(3, OP_REM, MIN_INT, ALL_ONES, acc);
    endtask

    task automatic run_back_to_back();
        word_t a;
        word_t b;
        int    acc;
        int    prev_acc;
        prev_acc = 0;
        for (int i = 0; i < N_B2B; i++) begin
            a = $urandom();
            b = $urandom() >> ($urandom() % 32);
            send_op(4, div_op_t'($urandom() % 4), a, b, acc);
            // Each issue goes in as busy falls, so acceptances sit LATENCY edges apart.
            if (i > 0) begin
                if (acc - prev_acc != LATENCY) begin
                    $display("Mismatch in %s: issue spacing expected %0d edges, actual %0d",
                             test_name[4], LATENCY, acc - prev_acc);
                    record_check(4, 1'b0);
                end else begin
                    record_check(4, 1'b1);
                end
            end
            prev_acc = acc;
        end
    endtask

    task automatic run_busy_issue();
        word_t   a;
        word_t   b;
        div_op_t o;
        int      acc;
        int      wait_cycles;
        for (int i = 0; i < N_BUSY; i++) begin
            a = $urandom();
            b = ($urandom() >> ($urandom() % 24)) | 32'd1;
            o = div_op_t'($urandom() % 4);
            send_op(5, o, a, b, acc);
            wait_cycles = 2 + ($urandom() % 28);
            repeat (wait_cycles) begin
                @(posedge clk);
                #1;
            end
            if (!busy) begin
                $display("Error in %s: busy was low while an operation was running",
                         test_name[5]);
                record_check(5, 1'b0);
            end else begin
                record_check(5, 1'b1);
            end
            issue = 1'b1;                        // Different opcode and operands.
            op    = ~o;
            rs1   = ~a;
            rs2   = b + 32'd7;
            @(posedge clk);
            #1;
            issue = 1'b0;
        end
    endtask

    // Compare process. Outputs are sampled on the falling edge.
    initial begin
        word_t exp_val;
        int    id;
        int    issued_at;
        forever begin
            @(negedge clk);
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Error in %s: result_valid with no operation pending, result %h",
                             test_name[cur_test], result);
                    record_check(cur_test, 1'b0);
                end else begin
                    exp_val   = exp_q.pop_front();
                    id        = id_q.pop_front();
                    issued_at = cyc_q.pop_front();
                    if (result !== exp_val) begin
                        $display("Mismatch in %s: expected %h, actual %h",
                                 test_name[id], exp_val, result);
                        record_check(id, 1'b0);
                    end else begin
                        record_check(id, 1'b1);
                    end
                    if (cycle - issued_at != LATENCY) begin
                        $display("Mismatch in %s latency: expected %0d edges, actual %0d",
                                 test_name[id], LATENCY, cycle - issued_at);
                        record_check(id, 1'b0);
                    end else begin
                        record_check(id, 1'b1);
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: run timed out after %0d ns with %0d results outstanding",
                 TIMEOUT_NS, exp_q.size());
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed_val = $urandom(32'hedef_c71e);      // Seeds the generator for the whole run.
        rst      = 1'b1;
        issue    = 1'b0;
        op       = OP_DIV;
        rs1      = '0;
        rs2      = '0;
        test_name[0] = "reset";
        test_name[1] = "unsigned";
        test_name[2] = "signed";
        test_name[3] = "corner";
        test_name[4] = "back_to_back";
        test_name[5] = "issue_while_busy";
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        rst = 1'b0;
        repeat (5) begin                         // Idle window before the first issue.
            @(posedge clk);
            #1;
            if (busy || result_valid) begin
                $display("Error in %s: busy or result_valid high after reset with no issue",
                         test_name[0]);
                record_check(0, 1'b0);
            end else begin
                record_check(0, 1'b1);
            end
        end
        finish_test(0);
        cur_test = 1;
        run_unsigned();
        finish_test(1);
        cur_test = 2;
        run_signed();
        finish_test(2);
        cur_test = 3;
        run_corners();
        finish_test(3);
        cur_test = 4;
        run_back_to_back();
        finish_test(4);
        cur_test = 5;
        run_busy_issue();
        repeat (40) @(posedge clk);              // A wrongly accepted issue would show up here.
        finish_test(5);
        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
